// ==== lsu_top.f ====
+incdir+.
riscv_lsu_pkg.sv
mem_bus_pkg.sv
credit_fifo.sv
lsu_decode.sv
mem.sv
lsu_result.sv
lsu_top.sv
lsu_checker.sv
lsu_monitor.sv
lsu_tb.sv

// ==== Makefile ====
# Verilator flow for the load/store unit testbench
TOP = lsu_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f lsu_top.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f lsu_top.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qx "Test passed"

clean:
	rm -rf obj_dir

// ==== lsu_tb.sv ====
// testbench top for the load/store unit
// clock, reset, LFSR stimulus, credit sender and consumer, timeout
`default_nettype none
`include "lsu_settings.svh"

module lsu_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import riscv_lsu_pkg::*;

  localparam int reset_cycles = 16;
  localparam int n_tests = 5;
  localparam int n_fill  = 64;   // words in the 256-byte region
  localparam int n_merge = 48;   // byte and halfword stores
  localparam int n_sub   = 96;   // sub-word loads
  localparam int n_rand  = 160;  // mixed commands under back-pressure
  localparam int n_cmds  = 2 * n_fill + n_merge + n_fill + n_sub + n_rand;
  localparam int limit   = n_cmds * 12 + reset_cycles;  // worst case 12 per command

  logic        clk;
  logic        reset;
  logic        cmd_valid;
  lsu_cmd_t    cmd;
  logic        cmd_credit;
  logic        res_valid;
  lsu_res_t    res;
  logic        res_credit;
  logic        test_done;
  int          test_num;
  int          errors, checks, pending;
  int          credits;   // sender side command credits
  int          held_res;  // results sitting in the consumer
  int          stall;     // cycles left of a withheld stretch
  logic        slow;
  logic [15:0] s_lfsr;    // stimulus
  logic [15:0] c_lfsr;    // consumer
  int          cycles;

  lsu_top i_dut (
    .clk, .reset, .cmd_valid, .cmd, .cmd_credit, .res_valid, .res, .res_credit
  );

  lsu_monitor i_monitor (
    .clk, .reset, .cmd_valid, .cmd, .cmd_credit, .res_valid, .res, .res_credit,
    .test_done, .test_num, .errors, .checks, .pending
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Galois LFSR, taps 16,14,13,11, one step per bit taken
  function automatic logic [31:0] take_bits(inout logic [15:0] s, input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      s = s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
      r = {r[30:0], s[0]};
    end
    return r;
  endfunction

  function automatic lsu_width_t width_of(logic store, int k);
    if (store) begin
      case (k % 3)
        0:       return lsu_b;
        1:       return lsu_h;
        default: return lsu_w;
      endcase
    end
    case (k % 5)
      0:       return lsu_b;
      1:       return lsu_bu;
      2:       return lsu_h;
      3:       return lsu_hu;
      default: return lsu_w;
    endcase
  endfunction

  // natural alignment forced here
  function automatic lsu_cmd_t make_cmd(logic store, lsu_width_t w, int adr,
                                        logic [31:0] d, int tag);
    lsu_cmd_t c;
    int       a;
    a = adr;
    case (w)
      lsu_h, lsu_hu: a = adr & ~1;
      lsu_w:         a = adr & ~3;
      default:       ;
    endcase
    c.store = store;
    c.width = w;
    c.adr   = a[`LSU_AW-1:0];
    c.wdt   = d;
    c.tag   = tag[3:0];
    return c;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // credit links
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (reset) credits <= `LSU_CMD_DEPTH;
    else credits <= credits - int'(cmd_valid) + int'(cmd_credit);
  end

  // consumer hands credits back at random, long gaps in slow mode
  always @(posedge clk) begin
    logic give;
    give = 1'b0;
    if (reset) begin
      held_res = 0;
      stall    = 0;
    end else begin
      held_res = held_res + int'(res_valid) - int'(res_credit);
      if (slow && stall == 0 && take_bits(c_lfsr, 3) == 0) begin
        stall = 16 + int'(take_bits(c_lfsr, 5));
      end
      if (stall > 0) stall--;
      else give = (held_res > 0) && (take_bits(c_lfsr, 1) == 1);
    end
    res_credit <= give;
  end

  task automatic send(input lsu_cmd_t c);
    @(posedge clk);
    while (credits == 0) @(posedge clk);
    cmd_valid <= 1'b1;
    cmd       <= c;
    @(posedge clk);
    cmd_valid <= 1'b0;
  endtask

  // wait until all owed results are in and all credits are home
  task automatic end_test();
    repeat (2) @(posedge clk);
    while (pending != 0 || credits != `LSU_CMD_DEPTH) @(posedge clk);
    repeat (4) @(posedge clk);
    test_done <= 1'b1;
    @(posedge clk);
    test_done <= 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int          adr;
    int          k;
    logic        st;
    logic [31:0] d;
    cmd_valid  = 1'b0;
    cmd        = '0;
    res_credit = 1'b0;
    test_done  = 1'b0;
    test_num   = 1;
    slow       = 1'b0;
    s_lfsr     = 16'd34984;
    c_lfsr     = 16'd34984;
    reset      = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    reset <= 1'b0;

    repeat (10) @(posedge clk);  // 1: idle link stays quiet
    end_test();

    test_num <= 2;  // word fill, word read back
    for (int i = 0; i < n_fill; i++) begin
      d = take_bits(s_lfsr, 32);
      send(make_cmd(1'b1, lsu_w, 4 * i, d, i));
    end
    for (int i = 0; i < n_fill; i++) send(make_cmd(1'b0, lsu_w, 4 * i, '0, i));
    end_test();

    test_num <= 3;  // sub-word stores merged into words
    for (int i = 0; i < n_merge; i++) begin
      st  = 1'(take_bits(s_lfsr, 1));
      adr = int'(take_bits(s_lfsr, 8));
      d   = take_bits(s_lfsr, 32);
      send(make_cmd(1'b1, st ? lsu_h : lsu_b, adr, d, i));
    end
    for (int i = 0; i < n_fill; i++) send(make_cmd(1'b0, lsu_w, 4 * i, '0, i));
    end_test();

    test_num <= 4;  // lb, lbu, lh, lhu over all offsets
    for (int i = 0; i < n_sub; i++) begin
      k   = int'(take_bits(s_lfsr, 2));
      adr = (i % 4) + 4 * int'(take_bits(s_lfsr, 6));
      send(make_cmd(1'b0, width_of(1'b0, k), adr, '0, i));
    end
    end_test();

    test_num <= 5;  // mixed traffic, consumer withholds credits
    slow = 1'b1;
    for (int i = 0; i < n_rand; i++) begin
      st  = 1'(take_bits(s_lfsr, 1));
      k   = int'(take_bits(s_lfsr, 3));
      adr = int'(take_bits(s_lfsr, 8));
      d   = take_bits(s_lfsr, 32);
      send(make_cmd(st, width_of(st, k), adr, d, int'(take_bits(s_lfsr, 4))));
    end
    end_test();

    @(posedge clk);
    $display("%0d tests, %0d checks, %0d errors", n_tests, checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  initial begin
    cycles = 0;
    while (cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout, the run did not finish within %0d cycles", limit);
    $display("Test failed");
    $finish;
  end

endmodule : lsu_tb

`default_nettype wire

// ==== lsu_monitor.sv ====
// reference model and comparisons for the load/store unit testbench
// byte memory, expected results in command order, credit bookkeeping
`default_nettype none
`include "lsu_settings.svh"

module lsu_monitor (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    cmd_valid,
  input  riscv_lsu_pkg::lsu_cmd_t cmd,
  input  logic                    cmd_credit,
  input  logic                    res_valid,
  input  riscv_lsu_pkg::lsu_res_t res,
  input  logic                    res_credit,
  input  logic                    test_done,  // close the current test
  input  int                      test_num,
  output int                      errors,
  output int                      checks,
  output int                      pending     // loads still owed a result
);
  timeunit 1ns;
  timeprecision 1ps;

  import riscv_lsu_pkg::*;

  logic [7:0] model [`LSU_MEM_BYTES];  // reference bytes
  lsu_res_t   expq [$];
  int         n_err, n_chk, t_err, t_chk;
  int         sent, cmd_back, got, res_back;
  logic       started;                 // first command seen

  // load value from the funct3 rule, little endian
  function automatic logic [31:0] load_value(lsu_cmd_t c);
    logic [7:0] b0;
    logic [7:0] b1;
    int         a;
    a  = int'(c.adr);
    b0 = model[a];
    b1 = model[a + 1];
    case (c.width)
      lsu_b:   return {{24{b0[7]}}, b0};
      lsu_bu:  return {24'h0, b0};
      lsu_h:   return {{16{b1[7]}}, b1, b0};
      lsu_hu:  return {16'h0, b1, b0};
      default: return {model[a + 3], model[a + 2], b1, b0};
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // sample at the rising edge
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    lsu_res_t want;
    int       a;
    if (reset) begin
      started  = 1'b0;
      sent     = 0;
      cmd_back = 0;
      got      = 0;
      res_back = 0;
      expq.delete();
    end else begin
      if (!started) begin
        t_chk++;
        if (cmd_credit || res_valid) begin
          $display("credit or result came out before any command was accepted");
          t_err++;
        end
      end
      if (cmd_valid) begin
        started = 1'b1;
        sent++;
        if (sent > cmd_back + `LSU_CMD_DEPTH) begin
          $display("sender pushed a command without a free credit");
          t_err++;
        end
        a = int'(cmd.adr);
        if (cmd.store) begin
          model[a] = cmd.wdt[7:0];
          if (cmd.width != lsu_b) model[a + 1] = cmd.wdt[15:8];
          if (cmd.width == lsu_w) begin
            model[a + 2] = cmd.wdt[23:16];
            model[a + 3] = cmd.wdt[31:24];
          end
        end else begin
          want.tag = cmd.tag;
          want.rdt = load_value(cmd);  // model as seen at acceptance
          expq.push_back(want);
        end
      end
      if (res_valid) begin
        got++;
        if (got > res_back + `LSU_RES_CREDITS) begin
          $display("result sent while the consumer had no free credit");
          t_err++;
        end
        if (expq.size() == 0) begin
          $display("result arrived with no load outstanding");
          t_err++;
        end else begin
          want = expq.pop_front();
          t_chk++;
          if (res.tag !== want.tag) begin
            $display("FAIL res.tag expected %h actual %h", want.tag, res.tag);
            t_err++;
          end
          if (res.rdt !== want.rdt) begin
            $display("FAIL res.rdt expected %08h actual %08h", want.rdt, res.rdt);
            t_err++;
          end
        end
      end
      cmd_back += int'(cmd_credit);  // usable from the next cycle on
      res_back += int'(res_credit);
      if (cmd_back > sent) begin
        $display("command credit returned with no command outstanding");
        t_err++;
      end
      if (test_done) begin
        $display("test %0d: %0d checks, %0d errors", test_num, t_chk, t_err);
        n_chk += t_chk;
        n_err += t_err;
        t_chk = 0;
        t_err = 0;
      end
    end
    errors  <= n_err + t_err;
    checks  <= n_chk + t_chk;
    pending <= expq.size();
  end

endmodule : lsu_monitor

`default_nettype wire

// ==== lsu_checker.sv ====
// concurrent assertions on the memory request, result push and reset
// bound into the load/store unit top level
`default_nettype none
`include "lsu_settings.svh"

module lsu_checker (
  input logic                  clk,
  input logic                  reset,
  input logic                  req,
  input mem_bus_pkg::mem_req_t mem_req,
  input mem_bus_pkg::mem_ld_t  mem_ld,        // width and offset beside the request
  input logic                  push,
  input logic                  space_credit,  // result queue popped
  input logic                  res_valid
);
  timeunit 1ns;
  timeprecision 1ps;

  import riscv_lsu_pkg::*;

  localparam int unsigned ow = $clog2(`LSU_RES_DEPTH + 1);

  logic [ow-1:0] occupied;  // result queue entries

  always_ff @(posedge clk) begin
    if (reset) begin
      occupied <= '0;
    end else begin
      occupied <= occupied + ow'(push) - ow'(space_credit);
    end
  end

  // halfwords on even bytes, words on word boundaries
  a_aligned: assert property (@(posedge clk) disable iff (reset)
    req |-> (mem_ld.off == '0 || mem_ld.width inside {lsu_b, lsu_bu} ||
             (mem_ld.width inside {lsu_h, lsu_hu} && !mem_ld.off[0])))
    else $error("misaligned access, width %b offset %0d", mem_ld.width, mem_ld.off);

  a_sel_set: assert property (@(posedge clk) disable iff (reset)
    req |-> (mem_req.sel != '0))
    else $error("request with empty byte select");

  a_push_room: assert property (@(posedge clk) disable iff (reset)
    push |-> (occupied < ow'(`LSU_RES_DEPTH)))
    else $error("result pushed into a full result queue");

  a_quiet_reset: assert property (@(posedge clk) $fell(reset) |-> !res_valid)
    else $error("res_valid high right after reset");

endmodule : lsu_checker

bind lsu_top lsu_checker i_checker (
  .clk (clk), .reset (reset), .req (req), .mem_req (mem_req), .mem_ld (mem_ld),
  .push (push), .space_credit (space_credit), .res_valid (res_valid)
);

`default_nettype wire

// ==== lsu_top.sv ====
// load/store unit top level
// command queue, decode, memory, result stage and result queue
`default_nettype none
`include "lsu_settings.svh"

module lsu_top (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    cmd_valid,
  input  riscv_lsu_pkg::lsu_cmd_t cmd,
  output logic                    cmd_credit,
  output logic                    res_valid,
  output riscv_lsu_pkg::lsu_res_t res,
  input  logic                    res_credit
);

  import riscv_lsu_pkg::*;
  import mem_bus_pkg::*;

  logic               q_valid;       // command queue to decode
  lsu_cmd_t           q_cmd;
  logic               cmd_grant;
  logic               space_credit;  // result queue popped
  logic               req;
  mem_req_t           mem_req;
  logic               ld_valid;
  mem_ld_t            mem_ld;
  logic [`LSU_DW-1:0] rdt;
  logic               push;
  lsu_res_t           res_d;

  //////////////////////////////////////////////////////////////////////
  // command side
  //////////////////////////////////////////////////////////////////////

  credit_fifo #(
    .payload_t    (lsu_cmd_t),
    .depth        (`LSU_CMD_DEPTH),
    .init_credits (`LSU_DEC_CREDITS)
  ) u_cmd_fifo (
    .clk, .reset,
    .in_valid  (cmd_valid), .in_data  (cmd),   .in_credit  (cmd_credit),
    .out_valid (q_valid),   .out_data (q_cmd), .out_credit (cmd_grant)
  );

  lsu_decode u_decode (
    .clk, .reset,
    .cmd_valid (q_valid), .cmd (q_cmd), .cmd_grant, .space_credit,
    .req, .mem_req, .ld_valid, .mem_ld
  );

  //////////////////////////////////////////////////////////////////////
  // memory and result side
  //////////////////////////////////////////////////////////////////////

  mem #(.dw(`LSU_DW), .sz(`LSU_MEM_BYTES)) u_mem (
    .clk, .req,
    .wen (mem_req.wen), .sel (mem_req.sel), .adr (mem_req.adr), .wdt (mem_req.wdt),
    .rdt, .ack ()  // never stalls
  );

  lsu_result u_result (.clk, .reset, .ld_valid, .mem_ld, .rdt, .push, .res (res_d));

  credit_fifo #(
    .payload_t    (lsu_res_t),
    .depth        (`LSU_RES_DEPTH),
    .init_credits (`LSU_RES_CREDITS)
  ) u_res_fifo (
    .clk, .reset,
    .in_valid  (push),      .in_data  (res_d), .in_credit  (space_credit),
    .out_valid (res_valid), .out_data (res),   .out_credit (res_credit)
  );

endmodule : lsu_top

`default_nettype wire

// ==== lsu_result.sv ====
// result stage of the load/store unit
// aligns load bytes, extends by funct3, pushes the result
`default_nettype none
`include "lsu_settings.svh"

module lsu_result (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    ld_valid,
  input  mem_bus_pkg::mem_ld_t    mem_ld,
  input  logic [`LSU_DW-1:0]      rdt,
  output logic                    push,
  output riscv_lsu_pkg::lsu_res_t res
);

  import riscv_lsu_pkg::*;
  import mem_bus_pkg::*;

  logic               ld_q_valid;  // data arrives this cycle
  mem_ld_t            ld_q;
  logic [`LSU_DW-1:0] shifted;
  logic [`LSU_DW-1:0] ext;

  // line the load info up with rdt
  always_ff @(posedge clk) begin
    if (reset) begin
      ld_q_valid <= 1'b0;
    end else begin
      ld_q_valid <= ld_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (ld_valid) begin
      ld_q <= mem_ld;
    end
  end

  assign shifted = rdt >> {ld_q.off, 3'b000};  // addressed byte to bit 0

  always_comb begin
    case (ld_q.width)
      lsu_b:   ext = {{(`LSU_DW-8){shifted[7]}}, shifted[7:0]};
      lsu_bu:  ext = {{(`LSU_DW-8){1'b0}}, shifted[7:0]};
      lsu_h:   ext = {{(`LSU_DW-16){shifted[15]}}, shifted[15:0]};
      lsu_hu:  ext = {{(`LSU_DW-16){1'b0}}, shifted[15:0]};
      default: ext = shifted;  // lw
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      push <= 1'b0;
    end else begin
      push <= ld_q_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (ld_q_valid) begin
      res.tag <= ld_q.tag;
      res.rdt <= ext;
    end
  end

endmodule : lsu_result

`default_nettype wire

// ==== mem.sv ====
// byte-select data memory, execute stage of the load/store unit
// write on the request edge, read data one cycle later
`default_nettype none

module mem #(
  parameter int unsigned dw = 32,            // data width
  parameter int unsigned sz = 4096,          // size in bytes
  parameter int unsigned sw = dw/8,          // byte lanes
  parameter int unsigned aw = $clog2(sz/sw)  // word address width
) (
  input  logic                 clk,
  input  logic                 req,  // access this cycle
  input  logic                 wen,  // 1 write, 0 read
  input  logic [sw-1:0]        sel,  // byte select
  input  logic [aw-1:0]        adr,  // word address
  input  logic [sw-1:0][8-1:0] wdt,
  output logic [sw-1:0][8-1:0] rdt,
  output logic                 ack
);

  logic [8-1:0] bytes [sz];

  //////////////////////////////////////////////////////////////////////
  // access
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (req) begin
      for (int i = 0; i < sw; i++) begin
        if (wen) begin
          if (sel[i]) begin
            bytes[int'(adr) * sw + i] <= wdt[i];
          end
        end else begin
          // lanes outside the select carry nothing
          rdt[i] <= sel[i] ? bytes[int'(adr) * sw + i] : 'x;
        end
      end
    end
  end

  // no wait states
  assign ack = 1'b1;

endmodule : mem

`default_nettype wire

// ==== lsu_decode.sv ====
// decode stage of the load/store unit
// holds one command, forms byte select and lane data, issues to memory
`default_nettype none
`include "lsu_settings.svh"

module lsu_decode (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    cmd_valid,
  input  riscv_lsu_pkg::lsu_cmd_t cmd,
  output logic                    cmd_grant,     // stage free again
  input  logic                    space_credit,  // result queue popped
  output logic                    req,
  output mem_bus_pkg::mem_req_t   mem_req,
  output logic                    ld_valid,
  output mem_bus_pkg::mem_ld_t    mem_ld
);

  import riscv_lsu_pkg::*;
  import mem_bus_pkg::*;

  localparam int unsigned spw = $clog2(`LSU_RES_DEPTH + 1);

  logic              held;      // stage occupied
  lsu_cmd_t          cmd_q;
  logic [spw-1:0]    space;     // free result slots
  logic              issue;
  logic              issue_ld;
  logic [mem_ow-1:0] off;
  logic [mem_sw-1:0] sel;

  assign off       = cmd_q.adr[mem_ow-1:0];
  // stores need no result space
  assign issue     = held && (cmd_q.store || (space != '0));
  assign issue_ld  = issue && !cmd_q.store;
  assign cmd_grant = issue;

  always_comb begin
    case (cmd_q.width)
      lsu_b, lsu_bu: sel = mem_sw'(1) << off;
      lsu_h, lsu_hu: sel = mem_sw'(3) << off;
      default:       sel = '1;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // hold register and space count
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      held  <= 1'b0;
      space <= spw'(`LSU_RES_DEPTH);
    end else begin
      if (cmd_valid) begin
        held <= 1'b1;
      end else if (issue) begin
        held <= 1'b0;
      end
      space <= space + spw'(space_credit) - spw'(issue_ld);
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_valid) begin
      cmd_q <= cmd;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // issue register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      req      <= 1'b0;
      ld_valid <= 1'b0;
    end else begin
      req      <= issue;
      ld_valid <= issue_ld;
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      mem_req.wen  <= cmd_q.store;
      mem_req.sel  <= sel;
      mem_req.adr  <= cmd_q.adr[mem_ow +: mem_aw];
      mem_req.wdt  <= cmd_q.wdt << {off, 3'b000};  // move onto its lanes
      mem_ld.tag   <= cmd_q.tag;
      mem_ld.width <= cmd_q.width;
      mem_ld.off   <= off;
    end
  end

endmodule : lsu_decode

`default_nettype wire

// ==== credit_fifo.sv ====
// credit-based queue for any payload type
// returns an input credit per pop, counts output credits
`default_nettype none

module credit_fifo #(
  parameter type         payload_t    = logic,
  parameter int unsigned depth        = 4,
  parameter int unsigned init_credits = 1
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     in_valid,    // sender spent a credit
  input  payload_t in_data,
  output logic     in_credit,   // one credit back per pop
  output logic     out_valid,
  output payload_t out_data,
  input  logic     out_credit   // receiver freed a slot
);

  localparam int unsigned pw = (depth > 1) ? $clog2(depth) : 1;
  localparam int unsigned cw = $clog2(depth + 1);
  localparam int unsigned kw = $clog2(init_credits + 1);

  payload_t      buffer [depth];
  logic [pw-1:0] wr_ptr;
  logic [pw-1:0] rd_ptr;
  logic [cw-1:0] count;    // entries held
  logic [kw-1:0] credits;  // receiver slots we may fill
  logic          pop;

  // pop whenever something waits and the far side has room
  assign pop       = (count != '0) && (credits != '0);
  assign out_valid = pop;
  assign out_data  = buffer[rd_ptr];
  assign in_credit = pop;

  //////////////////////////////////////////////////////////////////////
  // storage and pointers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (in_valid) begin
      buffer[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      credits <= kw'(init_credits);
    end else begin
      if (in_valid) begin
        wr_ptr <= (wr_ptr == pw'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == pw'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count   <= count + cw'(in_valid) - cw'(pop);
      credits <= credits + kw'(out_credit) - kw'(pop);  // both may hit at once
    end
  end

endmodule : credit_fifo

`default_nettype wire

// ==== mem_bus_pkg.sv ====
// memory-bus types
// request struct and side info for loads in flight
`default_nettype none
`include "lsu_settings.svh"

package mem_bus_pkg;

  localparam int unsigned mem_sw = `LSU_DW/8;        // byte lanes
  localparam int unsigned mem_ow = $clog2(mem_sw);   // byte offset bits
  localparam int unsigned mem_aw = `LSU_AW - mem_ow; // word address bits

  typedef struct packed {
    logic                     wen;
    logic [mem_sw-1:0]        sel;  // byte select
    logic [mem_aw-1:0]        adr;  // word address
    logic [mem_sw-1:0][8-1:0] wdt;  // data already on its lanes
  } mem_req_t;

  // travels beside a load until the data returns
  typedef struct packed {
    riscv_lsu_pkg::lsu_tag_t   tag;
    riscv_lsu_pkg::lsu_width_t width;
    logic [mem_ow-1:0]         off;  // byte offset in word
  } mem_ld_t;

endpackage : mem_bus_pkg

`default_nettype wire

// ==== riscv_lsu_pkg.sv ====
// instruction-side types of the load/store unit
// funct3 access widths, command and result structs
`default_nettype none
`include "lsu_settings.svh"

package riscv_lsu_pkg;

  // funct3 of loads, stores use lsu_b, lsu_h and lsu_w
  typedef enum logic [2:0] {
    lsu_b  = 3'b000,  // lb / sb
    lsu_h  = 3'b001,  // lh / sh
    lsu_w  = 3'b010,  // lw / sw
    lsu_bu = 3'b100,  // lbu
    lsu_hu = 3'b101   // lhu
  } lsu_width_t;

  typedef logic [3:0] lsu_tag_t;  // destination register tag

  // command from the core
  typedef struct packed {
    logic               store;  // 1 store, 0 load
    lsu_width_t         width;
    logic [`LSU_AW-1:0] adr;    // byte address
    logic [`LSU_DW-1:0] wdt;    // store data, low aligned
    lsu_tag_t           tag;
  } lsu_cmd_t;

  // load result back to the core
  typedef struct packed {
    lsu_tag_t           tag;
    logic [`LSU_DW-1:0] rdt;    // extended load data
  } lsu_res_t;

endpackage : riscv_lsu_pkg

`default_nettype wire

// ==== lsu_settings.svh ====
// width, memory size and credit depth macros for the load/store unit
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// data path
`define LSU_DW          32
`define LSU_MEM_BYTES   4096
`define LSU_AW          ($clog2(`LSU_MEM_BYTES))  // byte address bits

// queue sizes and credits
`define LSU_CMD_DEPTH   4  // sender starts with this many credits
`define LSU_RES_DEPTH   4  // result queue entries
`define LSU_RES_CREDITS 2  // consumer buffer size

// the command queue feeds a one-entry decode stage
`define LSU_DEC_CREDITS 1

`endif
